// ==== linear_proj_top.sv ====
// Linear-projection engine top level
// Controller, activation and weight RAMs, block MAC and accumulator
`timescale 1ns/100ps

`include "linproj_macros.svh"

module linear_proj_top
    import linproj_types_pkg::*;
    import linproj_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // Host activation write ports, even rows on A, odd rows on B
    input  ram_req_t     act_req_a,
    input  act_block_t   act_wdata_a,
    input  ram_req_t     act_req_b,
    input  act_block_t   act_wdata_b,
    // Host weight write port
    input  ram_req_t     wgt_req,
    input  wgt_block_t   wgt_wdata,
    // Results
    output proj_result_t result,
    output logic         out_valid,
    output logic         done,
    output logic         busy
);

    // RAM ports after the controller mux
    ram_req_t act_port_a;
    ram_req_t act_port_b;
    ram_req_t wgt_port_a;
    ram_req_t wgt_port_b;

    // RAM read data
    act_block_t act_rdata_a;
    act_block_t act_rdata_b;
    wgt_block_t wgt_rdata;

    // Pipeline signals
    blk_tag_t   ctrl_tag;
    blk_tag_t   mac_tag;
    psum_t      psum_even;
    psum_t      psum_odd;
    acc_t       sum_even;
    acc_t       sum_odd;
    logic       acc_done;
    logic       row_pair;
    logic [1:0] col;

    linproj_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_act_a (act_req_a),
        .host_act_b (act_req_b),
        .host_wgt   (wgt_req),
        .acc_done   (acc_done),
        .act_port_a (act_port_a),
        .act_port_b (act_port_b),
        .wgt_port_a (wgt_port_a),
        .wgt_port_b (wgt_port_b),
        .tag        (ctrl_tag),
        .row_pair   (row_pair),
        .col        (col),
        .out_valid  (out_valid),
        .done       (done),
        .busy       (busy)
    );

    // Activation RAM, row-major blocks
    linproj_bram #(
        .word_t (act_block_t),
        .depth  (`LP_NUM_A_WORDS)
    ) u_act_ram (
        .clk     (clk),
        .req_a   (act_port_a),
        .wdata_a (act_wdata_a),
        .req_b   (act_port_b),
        .wdata_b (act_wdata_b),
        .rdata_a (act_rdata_a),
        .rdata_b (act_rdata_b)
    );

    // Weight RAM, written on A, read on B
    linproj_bram #(
        .word_t (wgt_block_t),
        .depth  (`LP_NUM_W_WORDS)
    ) u_wgt_ram (
        .clk     (clk),
        .req_a   (wgt_port_a),
        .wdata_a (wgt_wdata),
        .req_b   (wgt_port_b),
        .wdata_b ('0),
        .rdata_a (),
        .rdata_b (wgt_rdata)
    );

    linproj_block_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_even  (act_rdata_a),
        .act_odd   (act_rdata_b),
        .wgt       (wgt_rdata),
        .tag_in    (ctrl_tag),
        .psum_even (psum_even),
        .psum_odd  (psum_odd),
        .tag_out   (mac_tag)
    );

    linproj_accum u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .psum_even (psum_even),
        .psum_odd  (psum_odd),
        .tag       (mac_tag),
        .sum_even  (sum_even),
        .sum_odd   (sum_odd),
        .acc_done  (acc_done)
    );

    // Held sums plus the pair indices still current at out_valid
    assign result = '{sum_even: sum_even, sum_odd: sum_odd, row_pair: row_pair, col: col};

endmodule

// ==== linproj_accum.sv ====
// Two-lane accumulator over the blocks of one output pair
// Pulses acc_done once the last block is in
`timescale 1ns/100ps

module linproj_accum
    import linproj_types_pkg::*;
    import linproj_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  psum_t    psum_even,
    input  psum_t    psum_odd,
    input  blk_tag_t tag,
    output acc_t     sum_even,
    output acc_t     sum_odd,
    output logic     acc_done
);

    // Running sums, held between pairs
    acc_t acc_even;
    acc_t acc_odd;
    logic done_q;

    // Block sums widened to the result width
    acc_t ext_even;
    acc_t ext_odd;

    assign ext_even = acc_t'(psum_even);
    assign ext_odd  = acc_t'(psum_odd);

    // First block loads, later blocks add
    always_ff @(posedge clk) begin
        if (tag.valid) begin
            if (tag.first) begin
                acc_even <= ext_even;
                acc_odd  <= ext_odd;
            end else begin
                acc_even <= acc_even + ext_even;
                acc_odd  <= acc_odd + ext_odd;
            end
        end
    end

    // One-cycle strobe after the closing block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= tag.valid && tag.last;
        end
    end

    assign sum_even = acc_even;
    assign sum_odd  = acc_odd;
    assign acc_done = done_q;

endmodule

// ==== linproj_block_mac.sv ====
// Two-lane block dot product
// Products in the first stage, block sums in the second
`timescale 1ns/100ps

`include "linproj_macros.svh"

module linproj_block_mac
    import linproj_types_pkg::*;
    import linproj_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  act_block_t act_even,
    input  act_block_t act_odd,
    input  wgt_block_t wgt,
    input  blk_tag_t   tag_in,
    output psum_t      psum_even,
    output psum_t      psum_odd,
    output blk_tag_t   tag_out
);

    // Stage 1 element products, full 16-bit signed
    logic signed [2*`LP_DATA_W-1:0] prod_even [`LP_BLOCK];
    logic signed [2*`LP_DATA_W-1:0] prod_odd  [`LP_BLOCK];
    blk_tag_t                       tag_s1;

    // Stage 2 block sums
    psum_t    sum_even;
    psum_t    sum_odd;
    blk_tag_t tag_s2;

    // Same weight block feeds both lanes
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LP_BLOCK; i++) begin
            prod_even[i] <= $signed(act_even[i]) * $signed(wgt[i]);
            prod_odd[i]  <= $signed(act_odd[i]) * $signed(wgt[i]);
        end
    end

    // Adder tree collapsed into a loop, sign-extended into psum width
    always_comb begin
        sum_even = '0;
        sum_odd  = '0;
        for (int i = 0; i < `LP_BLOCK; i++) begin
            sum_even = sum_even + psum_t'(prod_even[i]);
            sum_odd  = sum_odd + psum_t'(prod_odd[i]);
        end
    end

    always_ff @(posedge clk) begin
        psum_even <= sum_even;
        psum_odd  <= sum_odd;
    end

    // Tag follows the data through both stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_s1 <= '0;
            tag_s2 <= '0;
        end else begin
            tag_s1 <= tag_in;
            tag_s2 <= tag_s1;
        end
    end

    assign tag_out = tag_s2;

endmodule

// ==== linproj_bram.sv ====
// True dual-port RAM with a type-parameter word
// and a registered read port on each side
`timescale 1ns/100ps

module linproj_bram
    import linproj_ctrl_pkg::*;
#(
    parameter type word_t = logic [31:0],
    parameter int  depth  = 8
) (
    input  logic     clk,
    input  ram_req_t req_a,
    input  word_t    wdata_a,
    input  ram_req_t req_b,
    input  word_t    wdata_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    // Storage array
    word_t mem [depth];

    // Both ports share one process
    // On a same-address write collision port B lands last and wins
    always_ff @(posedge clk) begin
        // Port A
        if (req_a.en && req_a.we) begin
            mem[req_a.addr] <= wdata_a;
        end
        if (req_a.en && !req_a.we) begin
            rdata_a <= mem[req_a.addr];
        end

        // Port B
        if (req_b.en && req_b.we) begin
            mem[req_b.addr] <= wdata_b;
        end
        if (req_b.en && !req_b.we) begin
            rdata_b <= mem[req_b.addr];
        end
    end

endmodule

// ==== linproj_ctrl.sv ====
// Controller: write/compute phase, RAM port multiplexing, read addressing,
// row and column stepping, result strobe and done level
`timescale 1ns/100ps

`include "linproj_macros.svh"

module linproj_ctrl
    import linproj_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ram_req_t   host_act_a,
    input  ram_req_t   host_act_b,
    input  ram_req_t   host_wgt,
    input  logic       acc_done,
    output ram_req_t   act_port_a,
    output ram_req_t   act_port_b,
    output ram_req_t   wgt_port_a,
    output ram_req_t   wgt_port_b,
    output blk_tag_t   tag,
    output logic       row_pair,
    output logic [1:0] col,
    output logic       out_valid,
    output logic       done,
    output logic       busy
);

    // Counter widths
    localparam int blk_w  = ($clog2(`LP_KB) > 0) ? $clog2(`LP_KB) : 1;
    localparam int pair_w = $clog2(`LP_NUM_PAIRS + 1);

    // Address of the word the host writes last
    localparam logic [`LP_ADDR_A-1:0] last_act_addr = `LP_ADDR_A'(`LP_NUM_A_WORDS - 1);

    // Phase and sequencing state
    logic              write_phase;
    logic              issue;
    logic [blk_w-1:0]  blk;
    logic              row_q;
    logic [1:0]        col_q;
    logic [pair_w-1:0] pair_cnt;
    blk_tag_t          tag_q;
    logic              out_valid_q;
    logic              done_q;

    // Decodes
    logic                  last_write;
    logic                  blk_last;
    logic                  step_pair;
    logic [`LP_ADDR_A-1:0] rd_addr_a;
    logic [`LP_ADDR_A-1:0] rd_addr_b;
    logic [`LP_ADDR_W-1:0] rd_addr_w;

    // Port A write to the final activation word closes the write phase
    assign last_write = write_phase && host_act_a.en && host_act_a.we &&
                        (host_act_a.addr == last_act_addr);

    assign blk_last = (int'(blk) == `LP_KB - 1);

    // Move to the next pair after every result but the last one
    assign step_pair = out_valid_q && !done_q;

    // Even row 2r on port A, odd row 2r+1 on port B
    assign rd_addr_a = `LP_ADDR_A'(int'(blk) + `LP_KB * (2 * int'(row_q)));
    assign rd_addr_b = `LP_ADDR_A'(int'(blk) + `LP_KB * (2 * int'(row_q) + 1));
    // Weights stored column by column
    assign rd_addr_w = `LP_ADDR_W'(int'(blk) + `LP_KB * int'(col_q));

    // Port multiplexing
    always_comb begin
        if (write_phase) begin
            // Host owns the write ports
            act_port_a = host_act_a;
            act_port_b = host_act_b;
            wgt_port_a = host_wgt;
        end else begin
            // Compute: RAMs stay on, host writes blocked
            act_port_a = '{en: 1'b1, we: 1'b0, addr: rd_addr_a};
            act_port_b = '{en: 1'b1, we: 1'b0, addr: rd_addr_b};
            wgt_port_a = '{en: 1'b1, we: 1'b0, addr: host_wgt.addr};
        end
        // Weight port B is a read port in both phases
        wgt_port_b = '{en: 1'b1, we: 1'b0, addr: rd_addr_w};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_phase <= 1'b1;
            issue       <= 1'b0;
            blk         <= '0;
            row_q       <= 1'b0;
            col_q       <= '0;
            pair_cnt    <= '0;
            tag_q       <= '0;
            out_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            // Tag lines up with RAM read data one cycle after the address
            tag_q.valid <= issue;
            tag_q.first <= issue && (blk == '0);
            tag_q.last  <= issue && blk_last;

            // Result strobe trails the accumulator by one cycle
            out_valid_q <= acc_done;

            // Done latches alongside the final result strobe
            if (acc_done && (int'(pair_cnt) == `LP_NUM_PAIRS - 1)) begin
                done_q <= 1'b1;
            end

            // Leave the write phase and start the first pair
            if (last_write) begin
                write_phase <= 1'b0;
                issue       <= 1'b1;
            end

            // Block counter, runs LP_KB cycles per pair
            if (issue) begin
                if (blk_last) begin
                    blk   <= '0;
                    issue <= 1'b0;
                end else begin
                    blk <= blk + 1'b1;
                end
            end

            // Column first, then row pair
            if (step_pair) begin
                pair_cnt <= pair_cnt + 1'b1;
                issue    <= 1'b1;
                if (int'(col_q) == `LP_COLS - 1) begin
                    col_q <= '0;
                    row_q <= ~row_q;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    assign tag       = tag_q;
    assign row_pair  = row_q;
    assign col       = col_q;
    assign out_valid = out_valid_q;
    assign done      = done_q;
    // High from the end of loading until the last result
    assign busy      = !write_phase && !done_q;

endmodule

// ==== linproj_ctrl_pkg.sv ====
// Control types: RAM port request and pipeline block tag

`include "linproj_macros.svh"

package linproj_ctrl_pkg;

    // Request for one RAM port
    // Write when en and we, read when en alone
    typedef struct packed {
        // Port enable
        logic                  en;
        // Write enable
        logic                  we;
        // Word address
        logic [`LP_ADDR_A-1:0] addr;
    } ram_req_t;

    // Marker that travels with a block through the pipeline
    typedef struct packed {
        // Block present on this cycle
        logic valid;
        // First block of an output pair, restarts the accumulator
        logic first;
        // Last block of an output pair, closes the sum
        logic last;
    } blk_tag_t;

endpackage

// ==== linproj_macros.svh ====
// Matrix geometry sizes and derived counts for the linear-projection engine
`ifndef LINPROJ_MACROS_SVH
`define LINPROJ_MACROS_SVH

// Rows of A, must be even since rows are processed in pairs
`define LP_ROWS 4
// Inner dimension shared by A and W
`define LP_INNER 8
// Columns of W and of C
`define LP_COLS 3
// Elements packed into one RAM word
`define LP_BLOCK 4

// Element and sum widths
`define LP_DATA_W 8
`define LP_PSUM_W 18
`define LP_ACC_W 20

// Blocks per row of A or column of W
`define LP_KB (`LP_INNER / `LP_BLOCK)
// Activation RAM depth, row-major blocks
`define LP_NUM_A_WORDS (`LP_ROWS * `LP_KB)
// Weight RAM depth, column-major blocks
`define LP_NUM_W_WORDS (`LP_COLS * `LP_KB)

// RAM address widths
`define LP_ADDR_A 3
`define LP_ADDR_W 3

// Output pairs, one per row pair and column
`define LP_NUM_PAIRS ((`LP_ROWS / 2) * `LP_COLS)

`endif

// ==== linproj_types_pkg.sv ====
// Data types: activations, weights, RAM blocks, partial sums
// and the result record

`include "linproj_macros.svh"

package linproj_types_pkg;

    // Single signed activation element
    typedef logic signed [`LP_DATA_W-1:0] act_t;

    // Single signed weight element
    typedef logic signed [`LP_DATA_W-1:0] wgt_t;

    // One activation RAM word
    // Element 0 sits in the low byte
    typedef act_t [`LP_BLOCK-1:0] act_block_t;

    // One weight RAM word, same packing as activations
    typedef wgt_t [`LP_BLOCK-1:0] wgt_block_t;

    // Dot product of one block
    // 16-bit products, four of them, need two guard bits
    typedef logic signed [`LP_PSUM_W-1:0] psum_t;

    // Finished element of C
    typedef logic signed [`LP_ACC_W-1:0] acc_t;

    // Result record for one row pair and column
    typedef struct packed {
        // Element of C for the even row
        acc_t       sum_even;
        // Element of C for the odd row
        acc_t       sum_odd;
        // Row pair index, rows 2r and 2r+1
        logic       row_pair;
        // Column of C
        logic [1:0] col;
    } proj_result_t;

endpackage

// ==== project.f ====
+incdir+.
linproj_types_pkg.sv
linproj_ctrl_pkg.sv
linproj_bram.sv
linproj_ctrl.sv
linproj_block_mac.sv
linproj_accum.sv
linear_proj_top.sv
tb_linear_proj.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; a nonzero exit status means failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_linear_proj -f project.f -o tb_linear_proj \
    && ./obj_dir/tb_linear_proj \
    || exit 1

// ==== tb_linear_proj.sv ====
// Testbench for the linear-projection engine
// Random A and W, reference dot products, assertion checks and run watchdog
`timescale 1ns/100ps

`include "linproj_macros.svh"

module tb_linear_proj
    import linproj_types_pkg::*;
    import linproj_ctrl_pkg::*;
;

    // Cycle budget: reset, loading, then every pair with margin, for two runs
    localparam int load_cycles    = 3 + `LP_NUM_W_WORDS + `LP_NUM_A_WORDS;
    localparam int run_cycles     = load_cycles + `LP_NUM_PAIRS * (`LP_KB + 5) + 20;
    localparam int timeout_cycles = 2 * run_cycles;

    logic         clk = 1'b0;
    logic         rst_n;
    ram_req_t     act_req_a;
    act_block_t   act_wdata_a;
    ram_req_t     act_req_b;
    act_block_t   act_wdata_b;
    ram_req_t     wgt_req;
    wgt_block_t   wgt_wdata;
    proj_result_t result;
    logic         out_valid;
    logic         done;
    logic         busy;

    // Model copies of A (row, inner) and W (inner, column)
    act_t act_mem [`LP_ROWS][`LP_INNER];
    wgt_t wgt_mem [`LP_INNER][`LP_COLS];

    // Checker state
    logic armed = 1'b0;
    logic loading = 1'b1;
    logic done_prev = 1'b0;
    int   pair_idx = 0;
    int   cycle_cnt = 0;

    linear_proj_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .act_req_a   (act_req_a),
        .act_wdata_a (act_wdata_a),
        .act_req_b   (act_req_b),
        .act_wdata_b (act_wdata_b),
        .wgt_req     (wgt_req),
        .wgt_wdata   (wgt_wdata),
        .result      (result),
        .out_valid   (out_valid),
        .done        (done),
        .busy        (busy)
    );

    // 100 ns clock
    initial begin
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("Result: FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic report_value_error(input string name, input logic [31:0] exp,
                                      input logic [31:0] act);
        $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
        fail_run($sformatf("%s does not match the expected value", name));
    endtask

    // Element of C, block sums at psum width then widened and added
    function automatic acc_t ref_dot(input int row, input int col);
        acc_t  acc;
        psum_t ps;
        acc = '0;
        for (int b = 0; b < `LP_KB; b++) begin
            ps = '0;
            for (int i = 0; i < `LP_BLOCK; i++) begin
                ps = ps + psum_t'(act_mem[row][b * `LP_BLOCK + i]) *
                          psum_t'(wgt_mem[b * `LP_BLOCK + i][col]);
            end
            acc = acc + acc_t'(ps);
        end
        return acc;
    endfunction

    // Activation word at addr, row-major blocks, element 0 in the low byte
    function automatic act_block_t act_word(input int addr);
        act_block_t w;
        for (int i = 0; i < `LP_BLOCK; i++) begin
            w[i] = act_mem[addr / `LP_KB][(addr % `LP_KB) * `LP_BLOCK + i];
        end
        return w;
    endfunction

    // Weight word at addr, stored column by column
    function automatic wgt_block_t wgt_word(input int addr);
        wgt_block_t w;
        for (int i = 0; i < `LP_BLOCK; i++) begin
            w[i] = wgt_mem[(addr % `LP_KB) * `LP_BLOCK + i][addr / `LP_KB];
        end
        return w;
    endfunction

    task automatic drive_idle();
        act_req_a   = '0;
        act_wdata_a = '0;
        act_req_b   = '0;
        act_wdata_b = '0;
        wgt_req     = '0;
        wgt_wdata   = '0;
    endtask

    task automatic fill_random();
        for (int r = 0; r < `LP_ROWS; r++) begin
            for (int k = 0; k < `LP_INNER; k++) begin
                act_mem[r][k] = act_t'($urandom);
            end
        end
        for (int k = 0; k < `LP_INNER; k++) begin
            for (int c = 0; c < `LP_COLS; c++) begin
                wgt_mem[k][c] = wgt_t'($urandom);
            end
        end
    endtask

    // Three reset cycles, checks armed once the first reset edge has passed
    task automatic apply_reset();
        armed = 1'b0;
        rst_n = 1'b0;
        drive_idle();
        @(posedge clk);
        #10;
        armed   = 1'b1;
        loading = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
    endtask

    // Weights first, then activations, final word through port A
    task automatic load_data();
        for (int a = 0; a < `LP_NUM_W_WORDS; a++) begin
            wgt_req   = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_W'(a)};
            wgt_wdata = wgt_word(a);
            @(posedge clk);
            #10;
        end
        drive_idle();
        for (int a = 0; a < `LP_NUM_A_WORDS - 1; a++) begin
            drive_idle();
            // Even rows on port A, odd rows on port B
            if ((a / `LP_KB) % 2 == 0) begin
                act_req_a   = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_A'(a)};
                act_wdata_a = act_word(a);
            end else begin
                act_req_b   = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_A'(a)};
                act_wdata_b = act_word(a);
            end
            @(posedge clk);
            #10;
        end
        drive_idle();
        act_req_a   = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_A'(`LP_NUM_A_WORDS - 1)};
        act_wdata_a = act_word(`LP_NUM_A_WORDS - 1);
        @(posedge clk);
        #10;
        drive_idle();
        loading = 1'b0;
    endtask

    // Random host writes on every port while the engine computes
    task automatic run_compute();
        while (!done) begin
            act_req_a   = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_A'($urandom)};
            act_wdata_a = act_block_t'($urandom);
            act_req_b   = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_A'($urandom)};
            act_wdata_b = act_block_t'($urandom);
            wgt_req     = '{en: 1'b1, we: 1'b1, addr: `LP_ADDR_W'($urandom)};
            wgt_wdata   = wgt_block_t'($urandom);
            @(posedge clk);
            #10;
        end
        drive_idle();
        // A few quiet cycles to catch stray pulses after done
        repeat (4) @(posedge clk);
        #10;
        assert (pair_idx == `LP_NUM_PAIRS)
            else report_value_error("out_valid count", `LP_NUM_PAIRS, pair_idx);
    endtask

    // One result against the model, in column-then-row order
    task automatic check_result();
        int   row_even;
        int   col_exp;
        acc_t exp_even;
        acc_t exp_odd;
        row_even = 2 * (pair_idx / `LP_COLS);
        col_exp  = pair_idx % `LP_COLS;
        exp_even = ref_dot(row_even, col_exp);
        exp_odd  = ref_dot(row_even + 1, col_exp);
        assert (int'(result.row_pair) == row_even / 2)
            else report_value_error("result.row_pair", row_even / 2, 32'(result.row_pair));
        assert (int'(result.col) == col_exp)
            else report_value_error("result.col", col_exp, 32'(result.col));
        assert (result.sum_even == exp_even)
            else report_value_error("result.sum_even", exp_even, result.sum_even);
        assert (result.sum_odd == exp_odd)
            else report_value_error("result.sum_odd", exp_odd, result.sum_odd);
        // done rises together with the last pulse only
        assert (done == (pair_idx == `LP_NUM_PAIRS - 1))
            else report_value_error("done", 32'(pair_idx == `LP_NUM_PAIRS - 1), 32'(done));
        pair_idx++;
    endtask

    // Outputs idle from reset through loading
    idle_check: assert property (@(negedge clk)
        !(armed && loading) || (!out_valid && !done && !busy))
        else report_value_error("out_valid/done/busy", 32'h0, {29'h0, out_valid, done, busy});

    // busy covers the compute phase until done
    busy_check: assert property (@(negedge clk) !(armed && !loading) || (busy == !done))
        else report_value_error("busy", 32'(!done), 32'(busy));

    // Result and done checks on the falling edge, where outputs are settled
    always @(negedge clk) begin
        if (armed !== 1'b1) begin
            done_prev = 1'b0;
            pair_idx  = 0;
        end else begin
            if (done_prev) begin
                // done holds and no more results come
                assert (done) else report_value_error("done", 32'h1, 32'(done));
                assert (!out_valid)
                    else report_value_error("out_valid", 32'h0, 32'(out_valid));
            end else if (out_valid) begin
                check_result();
            end else begin
                assert (!done) else report_value_error("done", 32'h0, 32'(done));
            end
            done_prev = done;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            fail_run("timeout waiting for the engine to finish");
        end
    end

    initial begin
        void'($urandom(36692));
        rst_n = 1'b0;
        drive_idle();
        // Second pass shows reset brings back the write phase
        for (int run = 0; run < 2; run++) begin
            fill_random();
            apply_reset();
            load_data();
            run_compute();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
